/* logic/scrub_params.svh */
// Scrub sequencer parameters.
// Sizes of the scrubbed memory, the data word and the sparse state register.
`ifndef SCRUB_PARAMS_SVH
`define SCRUB_PARAMS_SVH

// Number of words in the memory that one scrub walks over.
`define SCRUB_DEPTH 16

// Address width, enough to reach SCRUB_DEPTH words.
`define SCRUB_ADDR_W 4

// Width of one memory word, which is also the LFSR width.
`define SCRUB_WORD_W 32

// Seed used in place of an all-zero seed, since the LFSR would lock up at zero.
`define SCRUB_DEFAULT_SEED 32'hACE1_5EED

// Width of the sparsely encoded sequencer state register.
`define SCRUB_STATE_W 6

`endif

/* logic/scrub_state_pkg.sv */
// Scrub sequencer state package.
// Sparse state encoding of the sequencer control machine.
`default_nettype none

`include "scrub_params.svh"

package scrub_state_pkg;

  // Raw contents of the state register, wide enough for every code.
  typedef logic [`SCRUB_STATE_W-1:0] state_raw_t;

  // Sequencer states.
  // Every pair of codes differs in at least three bits, so a single or
  // double bit upset never turns one legal state into another one.
  // All pairs here are in fact four bits apart.
  typedef enum logic [`SCRUB_STATE_W-1:0] {
    // Waiting for a start request.
    StIdle  = 6'b101001,
    // Walking the memory, one write per granted cycle.
    StWipe  = 6'b010011,
    // Walk finished, start_ack_o held until the request drops.
    StAck   = 6'b111110,
    // Terminal state after a fatal fault, left only through reset.
    StFatal = 6'b000100
  } state_e;

endpackage

`default_nettype wire

/* logic/scrub_data_pkg.sv */
// Scrub sequencer datapath package.
// Vector types for addresses, data words and the LFSR seed.
`default_nettype none

`include "scrub_params.svh"

package scrub_data_pkg;

  // Memory word address.
  typedef logic [`SCRUB_ADDR_W-1:0] addr_t;

  // One scrub data word as written to the memory.
  typedef logic [`SCRUB_WORD_W-1:0] word_t;

  // LFSR seed.
  // It has the width of the LFSR, which equals the word width, so the
  // LFSR state can be written out unchanged.
  typedef logic [`SCRUB_WORD_W-1:0] seed_t;

endpackage

`default_nettype wire

/* logic/sparse_fsm_flop.sv */
// Sparse FSM state register.
// Holds the sequencer state and flags any stored value outside the encoding.
`timescale 1ns/1ns
`default_nettype none

module sparse_fsm_flop (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  input  wire scrub_state_pkg::state_e state_i,
  output scrub_state_pkg::state_e      state_o,
  output logic                         state_err_o
);

  // The register holds raw bits, so an upset value is kept as it is and
  // can be recognized below instead of being squeezed into a legal code.
  scrub_state_pkg::state_raw_t state_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= scrub_state_pkg::state_raw_t'(scrub_state_pkg::StIdle);
    end else begin
      state_q <= scrub_state_pkg::state_raw_t'(state_i);
    end
  end

  assign state_o = scrub_state_pkg::state_e'(state_q);

  // Walk through every member of the enum and look for a match.
  // No match means the register holds a value that no state uses.
  always_comb begin
    scrub_state_pkg::state_e t;
    logic                    hit;
    hit = 1'b0;
    t   = t.first();
    for (int i = 0; i < t.num(); i++) begin
      hit = hit | (state_q == scrub_state_pkg::state_raw_t'(t));
      t   = t.next();
    end
    state_err_o = ~hit;
  end

endmodule

`default_nettype wire

/* logic/hardened_counter.sv */
// Hardened address counter.
// An up count and a mirrored down count whose sum is checked every cycle.
`timescale 1ns/1ns
`default_nettype none

`include "scrub_params.svh"

module hardened_counter (
  input  wire logic             clk_i,
  input  wire logic             rst_i,
  input  wire logic             clr_i,
  input  wire logic             step_i,
  output scrub_data_pkg::addr_t cnt_o,
  output logic                  last_o,
  output logic                  err_o
);

  // Address of the last word in the walk.
  localparam scrub_data_pkg::addr_t LastAddr = scrub_data_pkg::addr_t'(`SCRUB_DEPTH - 1);

  // Up half, which is the address handed out.
  scrub_data_pkg::addr_t up_q;
  // Down half, which always holds the bitwise complement of the up half.
  scrub_data_pkg::addr_t down_q;
  // Sum of both halves, all ones while they agree.
  scrub_data_pkg::addr_t sum;

  // Both halves move on the same strobes in opposite directions.
  // Clear wins over step, so a new walk always starts at zero.
  always_ff @(posedge clk_i) begin
    if (rst_i || clr_i) begin
      up_q   <= '0;
      down_q <= '1;
    end else if (step_i) begin
      up_q   <= up_q + 1'b1;
      down_q <= down_q - 1'b1;
    end
  end

  // The sum wraps at the address width.
  // Any flipped bit in either half breaks the all-ones result.
  assign sum   = up_q + down_q;
  assign err_o = (sum != '1);

  assign cnt_o = up_q;

  // Marks the final address of the walk.
  assign last_o = (up_q == LastAddr);

endmodule

`default_nettype wire

/* logic/scrub_lfsr.sv */
// Scrub pattern generator.
// A seeded 32-bit Galois LFSR whose state is the data word being written.
`timescale 1ns/1ns
`default_nettype none

`include "scrub_params.svh"

module scrub_lfsr (
  input  wire logic             clk_i,
  input  wire logic             rst_i,
  input  wire logic             load_i,
  input  wire scrub_data_pkg::seed_t seed_i,
  input  wire logic             step_i,
  output scrub_data_pkg::word_t word_o
);

  // Feedback mask applied when a one is shifted out of bit 0.
  localparam scrub_data_pkg::word_t Taps = 32'h80200003;

  scrub_data_pkg::word_t lfsr_q;
  scrub_data_pkg::word_t lfsr_next;

  // One Galois step to the right.
  always_comb begin
    lfsr_next = lfsr_q >> 1;
    if (lfsr_q[0]) begin
      lfsr_next = lfsr_next ^ Taps;
    end
  end

  // A zero seed would freeze the LFSR at zero, so the default is used
  // in its place.
  // Loading takes priority over stepping.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lfsr_q <= `SCRUB_DEFAULT_SEED;
    end else if (load_i) begin
      lfsr_q <= (seed_i == '0) ? `SCRUB_DEFAULT_SEED : seed_i;
    end else if (step_i) begin
      lfsr_q <= lfsr_next;
    end
  end

  assign word_o = lfsr_q;

endmodule

`default_nettype wire

/* logic/alert_sender.sv */
// Fatal alert sender.
// Reports the first fatal event once over a four-phase req/ack handshake.
`timescale 1ns/1ns
`default_nettype none

module alert_sender (
  input  wire logic clk_i,
  input  wire logic rst_i,
  input  wire logic fatal_i,
  output logic      alert_req_o,
  input  wire logic alert_ack_i
);

  // Handshake phases of the single alert.
  typedef enum logic [1:0] {
    AlIdle,
    AlReq,
    AlWaitLow,
    AlDone
  } al_state_e;

  al_state_e al_q;
  al_state_e al_d;

  always_comb begin
    al_d = al_q;
    case (al_q)
      // Nothing reported yet.
      AlIdle: begin
        if (fatal_i) begin
          al_d = AlReq;
        end
      end
      // Request held until the receiver acknowledges.
      AlReq: begin
        if (alert_ack_i) begin
          al_d = AlWaitLow;
        end
      end
      // Request dropped, waiting for the receiver to release ack.
      AlWaitLow: begin
        if (!alert_ack_i) begin
          al_d = AlDone;
        end
      end
      // The alert has been delivered.
      // Further fatal pulses are ignored until reset.
      default: al_d = AlDone;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      al_q <= AlIdle;
    end else begin
      al_q <= al_d;
    end
  end

  assign alert_req_o = (al_q == AlReq);

endmodule

`default_nettype wire

/* logic/scrub_fsm.sv */
// Scrub sequencer control machine.
// Runs the start handshake, walks the write port and handles fatal faults.
`timescale 1ns/1ns
`default_nettype none

module scrub_fsm (
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  input  wire logic                  start_req_i,
  input  wire scrub_data_pkg::seed_t seed_i,
  output logic                       start_ack_o,
  output logic                       wr_o,
  output scrub_data_pkg::addr_t      wr_addr_o,
  output scrub_data_pkg::word_t      wr_data_o,
  input  wire logic                  wr_gnt_i,
  input  wire logic                  esc_i,
  input  wire scrub_data_pkg::addr_t cnt_i,
  input  wire logic                  cnt_last_i,
  input  wire logic                  cnt_err_i,
  input  wire scrub_data_pkg::word_t word_i,
  output logic                       cnt_clr_o,
  output logic                       cnt_step_o,
  output logic                       lfsr_load_o,
  output scrub_data_pkg::seed_t      lfsr_seed_o,
  output logic                       lfsr_step_o,
  output logic                       fatal_o
);

  scrub_state_pkg::state_e state_d;
  scrub_state_pkg::state_e state_q;
  logic                    state_err;

  // A new walk starts when a request arrives while idle.
  logic start_go;
  // A write completes when the write is offered and granted.
  logic wr_done;
  // Any of the three fatal sources.
  logic fatal_cond;
  // Registered pulse for the first cycle spent in StFatal.
  logic fatal_q;

  sparse_fsm_flop u_state_flop (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .state_i    (state_d),
    .state_o    (state_q),
    .state_err_o(state_err)
  );

  assign fatal_cond = esc_i | state_err | cnt_err_i;

  assign start_go = (state_q == scrub_state_pkg::StIdle) & start_req_i & ~start_ack_o;
  assign wr_done  = wr_o & wr_gnt_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      scrub_state_pkg::StIdle: begin
        if (start_go) begin
          state_d = scrub_state_pkg::StWipe;
        end
      end
      // The 16th completed write ends the walk.
      scrub_state_pkg::StWipe: begin
        if (wr_done && cnt_last_i) begin
          state_d = scrub_state_pkg::StAck;
        end
      end
      // Ack stays up until the requester lets go of its request.
      scrub_state_pkg::StAck: begin
        if (!start_req_i) begin
          state_d = scrub_state_pkg::StIdle;
        end
      end
      scrub_state_pkg::StFatal: state_d = scrub_state_pkg::StFatal;
      default: state_d = scrub_state_pkg::StFatal;
    endcase
    // Fatal sources override every other transition.
    if (fatal_cond) begin
      state_d = scrub_state_pkg::StFatal;
    end
  end

  // The fatal pulse is high in the first cycle of StFatal only, since the
  // state cannot leave StFatal again before reset.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fatal_q <= 1'b0;
    end else begin
      fatal_q <= (state_d == scrub_state_pkg::StFatal) &&
                 (state_q != scrub_state_pkg::StFatal);
    end
  end

  assign fatal_o = fatal_q;

  // Outputs come straight from the registered state.
  assign start_ack_o = (state_q == scrub_state_pkg::StAck);
  assign wr_o        = (state_q == scrub_state_pkg::StWipe);
  // Address and data only move on a completed write, so they hold while
  // the grant is low.
  assign wr_addr_o   = cnt_i;
  assign wr_data_o   = word_i;

  // The counter is cleared and the LFSR seeded on the accepting edge.
  assign cnt_clr_o   = start_go & ~fatal_cond;
  assign lfsr_load_o = start_go & ~fatal_cond;
  assign lfsr_seed_o = seed_i;
  // Both step together on every completed write.
  assign cnt_step_o  = wr_done & ~fatal_cond;
  assign lfsr_step_o = wr_done & ~fatal_cond;

endmodule

`default_nettype wire

/* logic/scrub_top.sv */
// Memory scrub sequencer top level.
// Connects the control machine, address counter, LFSR and alert sender.
`timescale 1ns/1ns
`default_nettype none

module scrub_top (
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  input  wire logic                  start_req_i,
  input  wire scrub_data_pkg::seed_t seed_i,
  output logic                       start_ack_o,
  output logic                       wr_o,
  output scrub_data_pkg::addr_t      wr_addr_o,
  output scrub_data_pkg::word_t      wr_data_o,
  input  wire logic                  wr_gnt_i,
  input  wire logic                  esc_i,
  output logic                       alert_req_o,
  input  wire logic                  alert_ack_i
);

  // Counter side.
  scrub_data_pkg::addr_t cnt;
  logic                  cnt_last;
  logic                  cnt_err;
  logic                  cnt_clr;
  logic                  cnt_step;

  // Pattern generator side.
  scrub_data_pkg::word_t word;
  scrub_data_pkg::seed_t lfsr_seed;
  logic                  lfsr_load;
  logic                  lfsr_step;

  logic fatal;

  scrub_fsm u_fsm (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .start_req_i(start_req_i),
    .seed_i     (seed_i),
    .start_ack_o(start_ack_o),
    .wr_o       (wr_o),
    .wr_addr_o  (wr_addr_o),
    .wr_data_o  (wr_data_o),
    .wr_gnt_i   (wr_gnt_i),
    .esc_i      (esc_i),
    .cnt_i      (cnt),
    .cnt_last_i (cnt_last),
    .cnt_err_i  (cnt_err),
    .word_i     (word),
    .cnt_clr_o  (cnt_clr),
    .cnt_step_o (cnt_step),
    .lfsr_load_o(lfsr_load),
    .lfsr_seed_o(lfsr_seed),
    .lfsr_step_o(lfsr_step),
    .fatal_o    (fatal)
  );

  hardened_counter u_cnt (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .clr_i (cnt_clr),
    .step_i(cnt_step),
    .cnt_o (cnt),
    .last_o(cnt_last),
    .err_o (cnt_err)
  );

  scrub_lfsr u_lfsr (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .load_i(lfsr_load),
    .seed_i(lfsr_seed),
    .step_i(lfsr_step),
    .word_o(word)
  );

  alert_sender u_alert (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .fatal_i    (fatal),
    .alert_req_o(alert_req_o),
    .alert_ack_i(alert_ack_i)
  );

endmodule

`default_nettype wire

/* sim/scrub_tb.sv */
// Memory scrub sequencer testbench.
// Directed tests of reset, the write walk, back-pressure, zero seed and escalation.
`timescale 1ns/1ns
`default_nettype none

`include "scrub_params.svh"

module scrub_tb;

  // Four walks of SCRUB_DEPTH writes, with a generous factor for stalls.
  localparam int WalkCycles    = 4 * `SCRUB_DEPTH;
  localparam int TimeoutCycles = 10 * WalkCycles + 200;
  // Galois feedback mask of the data pattern.
  localparam scrub_data_pkg::word_t TapMask = 32'h80200003;

  logic                  clk;
  logic                  rst;
  logic                  start_req;
  scrub_data_pkg::seed_t seed;
  logic                  start_ack;
  logic                  wr;
  scrub_data_pkg::addr_t wr_addr;
  scrub_data_pkg::word_t wr_data;
  logic                  wr_gnt;
  logic                  esc;
  logic                  alert_req;
  logic                  alert_ack;

  int                    errors;
  int                    checks;
  int                    cycles;
  logic [31:0]           lcg_state;
  scrub_data_pkg::seed_t walk_seed;

  scrub_top DUT (
    .clk_i      (clk),
    .rst_i      (rst),
    .start_req_i(start_req),
    .seed_i     (seed),
    .start_ack_o(start_ack),
    .wr_o       (wr),
    .wr_addr_o  (wr_addr),
    .wr_data_o  (wr_data),
    .wr_gnt_i   (wr_gnt),
    .esc_i      (esc),
    .alert_req_o(alert_req),
    .alert_ack_i(alert_ack)
  );

  always #4 clk = ~clk;

  // Watchdog that stops a run which never reaches its end.
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("Run stopped: no result after %0d clock cycles.", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // One right step of the data pattern, with feedback when a one drops out.
  function automatic scrub_data_pkg::word_t pattern_next(input scrub_data_pkg::word_t w);
    scrub_data_pkg::word_t n;
    n = w >> 1;
    if (w[0]) begin
      n = n ^ TapMask;
    end
    return n;
  endfunction

  // First data word of a walk; a zero seed is replaced by the default.
  function automatic scrub_data_pkg::word_t pattern_first(input scrub_data_pkg::seed_t s);
    return (s == '0) ? `SCRUB_DEFAULT_SEED : s;
  endfunction

  // Linear congruential generator for seeds and grant patterns.
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Grant for the next cycle, either always on or a random high bit.
  function automatic logic grant_value(input logic random_gnt);
    logic [31:0] r;
    if (!random_gnt) begin
      return 1'b1;
    end
    r = lcg_next();
    return r[30];
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
    end
  endtask

  task automatic check_addr(input string name, input scrub_data_pkg::addr_t got,
                            input scrub_data_pkg::addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
    end
  endtask

  task automatic check_word(input string name, input scrub_data_pkg::word_t got,
                            input scrub_data_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
    end
  endtask

  // Outputs are low after reset and stay low while nobody asks for a scrub.
  task automatic idle_after_reset();
    repeat (6) begin
      @(negedge clk);
      check_bit("wr_o", wr, 1'b0);
      check_bit("start_ack_o", start_ack, 1'b0);
      check_bit("alert_req_o", alert_req, 1'b0);
    end
  endtask

  // One complete scrub from request to the end of the acknowledge.
  // Every offered write is checked; a granted one moves the model on.
  task automatic scrub_walk(input scrub_data_pkg::seed_t s, input logic random_gnt);
    scrub_data_pkg::word_t exp_word;
    scrub_data_pkg::addr_t exp_addr;
    int                    done;
    exp_word = pattern_first(s);
    exp_addr = '0;
    done     = 0;
    @(posedge clk);
    start_req <= 1'b1;
    seed      <= s;
    wr_gnt    <= grant_value(random_gnt);
    @(negedge clk);
    check_bit("wr_o", wr, 1'b0);
    // The request is sampled here, so the first write is offered next cycle.
    @(posedge clk);
    while (done < `SCRUB_DEPTH) begin
      @(negedge clk);
      check_bit("wr_o", wr, 1'b1);
      check_bit("start_ack_o", start_ack, 1'b0);
      check_addr("wr_addr_o", wr_addr, exp_addr);
      check_word("wr_data_o", wr_data, exp_word);
      if (wr_gnt) begin
        done++;
        exp_addr = exp_addr + 1'b1;
        exp_word = pattern_next(exp_word);
      end
      @(posedge clk);
      wr_gnt <= grant_value(random_gnt);
    end
    // The last write has completed, so the acknowledge is up.
    @(negedge clk);
    check_bit("wr_o", wr, 1'b0);
    check_bit("start_ack_o", start_ack, 1'b1);
    @(posedge clk);
    start_req <= 1'b0;
    wr_gnt    <= 1'b0;
    @(negedge clk);
    check_bit("start_ack_o", start_ack, 1'b1);
    @(posedge clk);
    @(negedge clk);
    check_bit("start_ack_o", start_ack, 1'b0);
    check_bit("wr_o", wr, 1'b0);
  endtask

  // Escalation in the middle of a walk, then the alert exchange.
  // A later start request must not restart the machine.
  task automatic escalate_mid_walk();
    @(posedge clk);
    start_req <= 1'b1;
    seed      <= lcg_next();
    wr_gnt    <= 1'b1;
    @(posedge clk);
    // Five writes complete with the grant held high.
    repeat (5) @(posedge clk);
    esc <= 1'b1;
    @(negedge clk);
    check_bit("wr_o", wr, 1'b1);
    check_addr("wr_addr_o", wr_addr, 4'd5);
    @(posedge clk);
    esc <= 1'b0;
    @(negedge clk);
    check_bit("wr_o", wr, 1'b0);
    check_bit("start_ack_o", start_ack, 1'b0);
    check_bit("alert_req_o", alert_req, 1'b0);
    @(negedge clk);
    check_bit("alert_req_o", alert_req, 1'b1);
    @(posedge clk);
    alert_ack <= 1'b1;
    @(negedge clk);
    check_bit("alert_req_o", alert_req, 1'b1);
    @(negedge clk);
    check_bit("alert_req_o", alert_req, 1'b0);
    @(posedge clk);
    alert_ack <= 1'b0;
    start_req <= 1'b0;
    @(posedge clk);
    start_req <= 1'b1;
    repeat (2 * `SCRUB_DEPTH) begin
      @(negedge clk);
      check_bit("wr_o", wr, 1'b0);
      check_bit("start_ack_o", start_ack, 1'b0);
      check_bit("alert_req_o", alert_req, 1'b0);
    end
    @(posedge clk);
    start_req <= 1'b0;
  endtask

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    start_req = 1'b0;
    seed      = '0;
    wr_gnt    = 1'b0;
    esc       = 1'b0;
    alert_ack = 1'b0;
    errors    = 0;
    checks    = 0;
    cycles    = 0;
    lcg_state = 32'd80588;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    idle_after_reset();
    // The same seed runs with and without stalls, so both walks match.
    walk_seed = lcg_next();
    scrub_walk(walk_seed, 1'b0);
    scrub_walk(walk_seed, 1'b1);
    scrub_walk('0, 1'b0);
    escalate_mid_walk();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+logic
logic/scrub_state_pkg.sv
logic/scrub_data_pkg.sv
logic/sparse_fsm_flop.sv
logic/hardened_counter.sv
logic/scrub_lfsr.sv
logic/alert_sender.sv
logic/scrub_fsm.sv
logic/scrub_top.sv
sim/scrub_tb.sv

/* Makefile */
# Verilator build and run of the scrub sequencer testbench.

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the simulation, then check the log for a pass"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -Wno-fatal --top-module scrub_tb \
		-Mdir obj_dir -o scrub_sim -f build.f
	./obj_dir/scrub_sim | tee $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
